//--- verilog.f
common/mips_pkg.sv
common/decode_if.sv
instr_decode/instr_decoder.sv
instr_decode/instr_classifier.sv
instr_decode/classify_stage.sv
source/mips_decode_top.sv
verification/decode_props.sv
verification/decode_checker.sv
verification/tb_mips_decode.sv

//--- verification/tb_mips_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the decode front end: clock, reset, stimulus table,
// input driver with back-pressure phases, final report.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mips_decode;
    import mips_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic        instr_ready;
    instr_word_t instr_word;
    logic        out_valid;
    logic        out_ready;
    sym_t        out_sym;
    format_t     out_format;
    func_t       out_func;
    reg_idx_t    out_rs;
    reg_idx_t    out_rt;
    reg_idx_t    out_dest;
    logic        out_dest_en;
    logic        check_latency;
    logic        rand_mode;
    integer      seed;
    int          waits;
    int          total_errors;

    string       name_tab[$];
    instr_word_t word_tab[$];
    logic [28:0] exp_tab[$]; // sym, format, func, rs, rt, dest, dest_en.

    mips_decode_top mips_decode_top_inst (.*);

    decode_checker decode_checker_inst (.*);

    bind mips_decode_top decode_props decode_props_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders and table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic instr_word_t r_word(input logic [5:0] op, input reg_idx_t rs,
                                           input reg_idx_t rt, input reg_idx_t rd,
                                           input logic [5:0] fn);
        return {op, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_word_t i_word(input logic [5:0] op, input reg_idx_t rs,
                                           input reg_idx_t rt);
        return {op, rs, rt, 16'h0024}; // immediate is not decoded.
    endfunction

    function automatic instr_word_t j_word(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic add_test(input string name, input instr_word_t word, input sym_t sym,
                            input format_t fmt, input func_t func, input reg_idx_t rs,
                            input reg_idx_t rt, input reg_idx_t dest, input logic dest_en);
        name_tab.push_back(name);
        word_tab.push_back(word);
        exp_tab.push_back({sym, fmt, func, rs, rt, dest, dest_en});
    endtask

    task automatic build_table();
        add_test("nop", 32'h0, SYM_NOP, FORMAT_R, FUNC_CALC_R, 0, 0, 0, 0);
        add_test("add", r_word(6'h00, 1, 2, 3, 6'h20), SYM_ADD, FORMAT_R, FUNC_CALC_R, 1, 2, 3, 1);
        add_test("sll_r0", r_word(6'h00, 0, 5, 0, 6'h00), SYM_SLL, FORMAT_R, FUNC_CALC_R,
                 0, 5, 0, 0);
        add_test("slt", r_word(6'h00, 8, 9, 10, 6'h2a), SYM_SLT, FORMAT_R, FUNC_CALC_R,
                 8, 9, 10, 1);
        add_test("clo", r_word(6'h1c, 4, 0, 6, 6'h21), SYM_CLO, FORMAT_R, FUNC_CALC_R, 4, 0, 6, 1);
        add_test("clz", r_word(6'h1c, 7, 0, 8, 6'h20), SYM_CLZ, FORMAT_R, FUNC_CALC_R, 7, 0, 8, 1);
        add_test("addi", i_word(6'h08, 9, 10), SYM_ADDI, FORMAT_I, FUNC_CALC_I, 9, 10, 10, 1);
        add_test("lui", i_word(6'h0f, 0, 11), SYM_LUI, FORMAT_I, FUNC_CALC_I, 0, 11, 11, 1);
        add_test("lw", i_word(6'h23, 29, 12), SYM_LW, FORMAT_I, FUNC_MEM_READ, 29, 12, 12, 1);
        add_test("lbu_r0", i_word(6'h24, 13, 0), SYM_LBU, FORMAT_I, FUNC_MEM_READ, 13, 0, 0, 0);
        add_test("sw", i_word(6'h2b, 29, 14), SYM_SW, FORMAT_I, FUNC_MEM_WRITE, 29, 14, 0, 0);
        add_test("sb", i_word(6'h28, 3, 15), SYM_SB, FORMAT_I, FUNC_MEM_WRITE, 3, 15, 0, 0);
        add_test("beq", i_word(6'h04, 1, 2), SYM_BEQ, FORMAT_I, FUNC_BRANCH, 1, 2, 0, 0);
        add_test("bltz", i_word(6'h01, 17, 0), SYM_BLTZ, FORMAT_I, FUNC_BRANCH, 17, 0, 0, 0);
        add_test("bgezal", i_word(6'h01, 18, 17), SYM_BGEZAL, FORMAT_I, FUNC_BRANCH,
                 18, 17, 31, 1);
        add_test("bltzal", i_word(6'h01, 19, 16), SYM_BLTZAL, FORMAT_I, FUNC_BRANCH,
                 19, 16, 31, 1);
        add_test("j", j_word(6'h02, 26'h40), SYM_J, FORMAT_J, FUNC_JUMP, 0, 0, 0, 0);
        add_test("jal", j_word(6'h03, 26'h100), SYM_JAL, FORMAT_J, FUNC_JUMP, 0, 0, 31, 1);
        add_test("jr", r_word(6'h00, 31, 0, 0, 6'h08), SYM_JR, FORMAT_R, FUNC_JUMP, 31, 0, 0, 0);
        add_test("jalr", r_word(6'h00, 20, 0, 31, 6'h09), SYM_JALR, FORMAT_R, FUNC_JUMP,
                 20, 0, 31, 1);
        add_test("mult", r_word(6'h00, 4, 5, 0, 6'h18), SYM_MULT, FORMAT_R, FUNC_MULTDIV,
                 4, 5, 0, 0);
        add_test("divu", r_word(6'h00, 6, 7, 0, 6'h1b), SYM_DIVU, FORMAT_R, FUNC_MULTDIV,
                 6, 7, 0, 0);
        add_test("mfhi", r_word(6'h00, 0, 0, 21, 6'h10), SYM_MFHI, FORMAT_R, FUNC_MULTDIV,
                 0, 0, 21, 1);
        add_test("mflo", r_word(6'h00, 0, 0, 22, 6'h12), SYM_MFLO, FORMAT_R, FUNC_MULTDIV,
                 0, 0, 22, 1);
        add_test("mthi", r_word(6'h00, 23, 0, 0, 6'h11), SYM_MTHI, FORMAT_R, FUNC_MULTDIV,
                 23, 0, 0, 0);
        add_test("madd", r_word(6'h1c, 8, 9, 0, 6'h00), SYM_MADD, FORMAT_R, FUNC_MULTDIV,
                 8, 9, 0, 0);
        add_test("msubu", r_word(6'h1c, 10, 11, 0, 6'h05), SYM_MSUBU, FORMAT_R, FUNC_MULTDIV,
                 10, 11, 0, 0);
        add_test("mfc0", r_word(6'h10, 0, 24, 12, 6'h00), SYM_MFC0, FORMAT_R, FUNC_CP0,
                 0, 24, 24, 1);
        add_test("mtc0", r_word(6'h10, 4, 25, 12, 6'h00), SYM_MTC0, FORMAT_R, FUNC_CP0,
                 4, 25, 0, 0);
        add_test("eret", 32'h4200_0018, SYM_ERET, FORMAT_R, FUNC_CP0, 16, 0, 0, 0);
        add_test("bad_op", i_word(6'h3f, 1, 2), SYM_INVALID, FORMAT_R, FUNC_OTHER, 1, 2, 0, 0);
        add_test("bad_funct", r_word(6'h00, 1, 2, 3, 6'h3f), SYM_INVALID, FORMAT_R, FUNC_OTHER,
                 1, 2, 0, 0);
        add_test("bad_regimm", i_word(6'h01, 5, 31), SYM_INVALID, FORMAT_R, FUNC_OTHER,
                 5, 31, 0, 0);
        add_test("bad_cop0", r_word(6'h10, 2, 3, 4, 6'h00), SYM_INVALID, FORMAT_R, FUNC_OTHER,
                 2, 3, 0, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string msg);
        $display("timeout: %s", msg);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic drive_out_ready();
        if (rand_mode) begin
            out_ready = ($random(seed) & 1) != 0;
        end
    endtask

    task automatic send_word(input int idx, output int waited);
        logic accepted;
        instr_valid = 1'b1;
        instr_word  = word_tab[idx];
        accepted    = 1'b0;
        waited      = 0;
        while (!accepted) begin
            @(posedge clk);
            accepted = instr_ready; // handshake as seen at the edge.
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run($sformatf("word %s was never accepted", name_tab[idx]));
            end
            #1;
            drive_out_ready();
        end
        decode_checker_inst.add_expected(name_tab[idx], exp_tab[idx]);
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while (decode_checker_inst.pending() != 0) begin
            @(posedge clk);
            #1;
            drive_out_ready();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                decode_checker_inst.report_leftover();
                abort_run("queued results never came out of the pipeline");
            end
        end
    endtask

    initial begin
        seed          = 48399;
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr_word    = '0;
        out_ready     = 1'b0;
        check_latency = 1'b0;
        rand_mode     = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        decode_checker_inst.check_value("reset", "out_valid", 0, 32'(out_valid));
        decode_checker_inst.check_value("reset", "instr_ready", 1, 32'(instr_ready));

        // full throughput, one word per cycle.
        out_ready     = 1'b1;
        check_latency = 1'b1;
        foreach (word_tab[i]) begin
            send_word(i, waits);
            decode_checker_inst.check_value(name_tab[i], "accept_edges", 1, waits);
        end
        instr_valid = 1'b0;
        drain_results();
        check_latency = 1'b0;

        // both registers full with the output stalled.
        out_ready = 1'b0;
        send_word(0, waits);
        send_word(1, waits);
        instr_valid = 1'b0;
        decode_checker_inst.check_value("fill", "instr_ready", 0, 32'(instr_ready));
        decode_checker_inst.check_value("fill", "out_valid", 1, 32'(out_valid));
        repeat (2) @(posedge clk);
        #1;
        decode_checker_inst.check_value("fill_hold", "instr_ready", 0, 32'(instr_ready));

        // random back-pressure.
        rand_mode = 1'b1;
        foreach (word_tab[i]) begin
            send_word(i, waits);
        end
        instr_valid = 1'b0;
        drain_results();
        rand_mode = 1'b0;
        out_ready = 1'b1;

        repeat (2) @(posedge clk);
        decode_checker_inst.report_leftover();
        total_errors = decode_checker_inst.errors + mips_decode_top_inst.decode_props_inst.fail_count;
        $display("results checked %0d, compare errors %0d, assertion failures %0d",
                 decode_checker_inst.checked, decode_checker_inst.errors,
                 mips_decode_top_inst.decode_props_inst.fail_count);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/decode_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result checker: in-order compare of DUT outputs with queued
// expected entries, and result latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               instr_valid,
    input logic               instr_ready,
    input logic               out_valid,
    input logic               out_ready,
    input mips_pkg::sym_t     out_sym,
    input mips_pkg::format_t  out_format,
    input mips_pkg::func_t    out_func,
    input mips_pkg::reg_idx_t out_rs,
    input mips_pkg::reg_idx_t out_rt,
    input mips_pkg::reg_idx_t out_dest,
    input logic               out_dest_en,
    input logic               check_latency
);
    string       name_q[$];
    logic [28:0] exp_q[$];
    int          accept_q[$]; // edge number of each accepted word.
    int          cycle = 0;
    int          checked = 0;
    int          errors = 0;

    task automatic add_expected(input string name, input logic [28:0] exp);
        name_q.push_back(name);
        exp_q.push_back(exp);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic report_leftover();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never arrived, first is %s", exp_q.size(), name_q[0]);
        end
    endtask

    task automatic check_result();
        logic [28:0] exp;
        string       name;
        int          accepted_at;
        if (exp_q.size() == 0 || accept_q.size() == 0) begin
            errors++;
            $display("result with symbol %0h arrived with no expected entry queued", out_sym);
        end else begin
            exp         = exp_q.pop_front();
            name        = name_q.pop_front();
            accepted_at = accept_q.pop_front();
            checked++;
            check_value(name, "sym", 32'(exp[28:22]), 32'(out_sym));
            check_value(name, "format", 32'(exp[21:20]), 32'(out_format));
            check_value(name, "func", 32'(exp[19:16]), 32'(out_func));
            check_value(name, "rs", 32'(exp[15:11]), 32'(out_rs));
            check_value(name, "rt", 32'(exp[10:6]), 32'(out_rt));
            check_value(name, "dest", 32'(exp[5:1]), 32'(out_dest));
            check_value(name, "dest_en", 32'(exp[0]), 32'(out_dest_en));
            if (check_latency) begin
                check_value(name, "latency", 2, cycle - accepted_at); // edges from accept.
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (instr_valid && instr_ready) begin
                accept_q.push_back(cycle);
            end
            if (out_valid && out_ready) begin
                check_result();
            end
        end
        cycle++;
    end

endmodule

//--- verification/decode_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output stream assertions, bound to the decode top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_props (
    input logic               clk,
    input logic               rst_n,
    input logic               out_valid,
    input logic               out_ready,
    input mips_pkg::sym_t     out_sym,
    input mips_pkg::format_t  out_format,
    input mips_pkg::func_t    out_func,
    input mips_pkg::reg_idx_t out_rs,
    input mips_pkg::reg_idx_t out_rt,
    input mips_pkg::reg_idx_t out_dest,
    input logic               out_dest_en
);
    import mips_pkg::*;

    int fail_count = 0;

    // stalled result must not move.
    hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_sym) && $stable(out_format)
            && $stable(out_func) && $stable(out_rs) && $stable(out_rt)
            && $stable(out_dest) && $stable(out_dest_en))
        else begin
            fail_count++;
            $error("output changed while stalled");
        end

    idle_in_reset: assert property (@(posedge clk) !rst_n && $past(!rst_n) |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

    j_is_jump: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_format == FORMAT_J |-> out_func == FUNC_JUMP)
        else begin
            fail_count++;
            $error("format J with a function class other than jump");
        end

endmodule

//--- source/mips_decode_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 decode front end, two stages.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mips_decode_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    input  mips_pkg::instr_word_t instr_word,
    output logic                  out_valid,
    input  logic                  out_ready,
    output mips_pkg::sym_t        out_sym,
    output mips_pkg::format_t     out_format,
    output mips_pkg::func_t       out_func,
    output mips_pkg::reg_idx_t    out_rs,
    output mips_pkg::reg_idx_t    out_rt,
    output mips_pkg::reg_idx_t    out_dest,
    output logic                  out_dest_en
);
    import mips_pkg::*;

    decode_if dec_bus ();

    instr_decoder instr_decoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (instr_valid),
        .in_ready (instr_ready),
        .in_word  (instr_word),
        .dec      (dec_bus.src)
    );

    classify_stage #(
        .REG_LINK (REG_RA) // links go to ra.
    ) classify_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec_bus.dst),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_sym     (out_sym),
        .out_format  (out_format),
        .out_func    (out_func),
        .out_rs      (out_rs),
        .out_rt      (out_rt),
        .out_dest    (out_dest),
        .out_dest_en (out_dest_en)
    );

endmodule

//--- instr_decode/classify_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second decode stage: classify and pick the write-back register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module classify_stage #(
    parameter mips_pkg::reg_idx_t REG_LINK = 5'd31
) (
    input  logic                clk,
    input  logic                rst_n,
    decode_if.dst               dec,
    output logic                out_valid,
    input  logic                out_ready,
    output mips_pkg::sym_t      out_sym,
    output mips_pkg::format_t   out_format,
    output mips_pkg::func_t     out_func,
    output mips_pkg::reg_idx_t  out_rs,
    output mips_pkg::reg_idx_t  out_rt,
    output mips_pkg::reg_idx_t  out_dest,
    output logic                out_dest_en
);
    import mips_pkg::*;

    format_t  format;
    func_t    func;
    reg_idx_t dest;

    instr_classifier instr_classifier_inst (
        .sym    (dec.sym),
        .format (format),
        .func   (func)
    );

    always_comb begin
        dest = '0; // no write-back.
        if (func == FUNC_CALC_R || dec.sym inside {SYM_MFHI, SYM_MFLO, SYM_JALR}) begin
            dest = dec.rd;
        end else if (func inside {FUNC_CALC_I, FUNC_MEM_READ} || dec.sym == SYM_MFC0) begin
            dest = dec.rt;
        end else if (dec.sym inside {SYM_JAL, SYM_BGEZAL, SYM_BLTZAL}) begin
            dest = REG_LINK;
        end
    end

    assign dec.ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (dec.ready) begin
            out_valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid && dec.ready) begin
            out_sym     <= dec.sym;
            out_format  <= format;
            out_func    <= func;
            out_rs      <= dec.rs;
            out_rt      <= dec.rt;
            out_dest    <= dest;
            out_dest_en <= (dest != '0); // r0 is never written.
        end
    end

endmodule

//--- instr_decode/instr_classifier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Symbol to instruction format and function class.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_classifier (
    input  mips_pkg::sym_t    sym,
    output mips_pkg::format_t format,
    output mips_pkg::func_t   func
);
    import mips_pkg::*;

    logic is_r;
    logic is_i;
    logic is_j;
    logic calc_r;
    logic calc_i;
    logic mem_r;
    logic mem_w;
    logic br;
    logic jmp;
    logic md;
    logic cp0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // function class groups
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign calc_r = sym inside {SYM_NOP, SYM_ADD, SYM_ADDU, SYM_SUB, SYM_SUBU,
                                SYM_AND, SYM_OR, SYM_XOR, SYM_NOR, SYM_SLT, SYM_SLTU,
                                SYM_SLL, SYM_SRL, SYM_SRA, SYM_SLLV, SYM_SRLV,
                                SYM_SRAV, SYM_CLO, SYM_CLZ};
    assign calc_i = sym inside {SYM_ADDI, SYM_ADDIU, SYM_ANDI, SYM_ORI, SYM_XORI,
                                SYM_LUI, SYM_SLTI, SYM_SLTIU};
    assign mem_r  = sym inside {SYM_LW, SYM_LH, SYM_LHU, SYM_LB, SYM_LBU};
    assign mem_w  = sym inside {SYM_SW, SYM_SH, SYM_SB};
    assign br     = sym inside {SYM_BEQ, SYM_BNE, SYM_BLEZ, SYM_BGTZ, SYM_BGEZ,
                                SYM_BLTZ, SYM_BGEZAL, SYM_BLTZAL};
    assign jmp    = sym inside {SYM_J, SYM_JAL, SYM_JR, SYM_JALR};
    assign md     = sym inside {SYM_MULT, SYM_MULTU, SYM_DIV, SYM_DIVU, SYM_MFHI,
                                SYM_MFLO, SYM_MTHI, SYM_MTLO, SYM_MADD, SYM_MADDU,
                                SYM_MSUB, SYM_MSUBU};
    assign cp0    = sym inside {SYM_MFC0, SYM_MTC0, SYM_ERET};

    // jr and jalr fall through to the R default.
    assign is_r = calc_r;
    assign is_i = calc_i || mem_r || mem_w || br;
    assign is_j = sym inside {SYM_J, SYM_JAL};

    assign format = is_r ? FORMAT_R :
                    is_i ? FORMAT_I :
                    is_j ? FORMAT_J :
                           FORMAT_R;

    // first matching group wins.
    assign func = calc_r ? FUNC_CALC_R    :
                  calc_i ? FUNC_CALC_I    :
                  mem_r  ? FUNC_MEM_READ  :
                  mem_w  ? FUNC_MEM_WRITE :
                  br     ? FUNC_BRANCH    :
                  jmp    ? FUNC_JUMP      :
                  md     ? FUNC_MULTDIV   :
                  cp0    ? FUNC_CP0       :
                           FUNC_OTHER;

endmodule

//--- instr_decode/instr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First decode stage: instruction word to symbol and register fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  mips_pkg::instr_word_t in_word,
    decode_if.src                 dec
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    sym_t       sym;

    assign opcode = in_word[31:26];
    assign rs     = in_word[25:21];
    assign rt     = in_word[20:16];
    assign rd     = in_word[15:11];
    assign funct  = in_word[5:0];

    always_comb begin
        sym = SYM_INVALID;
        if (in_word == '0) begin
            sym = SYM_NOP; // all-zero word, not sll.
        end else begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        6'h00: sym = SYM_SLL;
                        6'h02: sym = SYM_SRL;
                        6'h03: sym = SYM_SRA;
                        6'h04: sym = SYM_SLLV;
                        6'h06: sym = SYM_SRLV;
                        6'h07: sym = SYM_SRAV;
                        6'h08: sym = SYM_JR;
                        6'h09: sym = SYM_JALR;
                        6'h10: sym = SYM_MFHI;
                        6'h11: sym = SYM_MTHI;
                        6'h12: sym = SYM_MFLO;
                        6'h13: sym = SYM_MTLO;
                        6'h18: sym = SYM_MULT;
                        6'h19: sym = SYM_MULTU;
                        6'h1a: sym = SYM_DIV;
                        6'h1b: sym = SYM_DIVU;
                        6'h20: sym = SYM_ADD;
                        6'h21: sym = SYM_ADDU;
                        6'h22: sym = SYM_SUB;
                        6'h23: sym = SYM_SUBU;
                        6'h24: sym = SYM_AND;
                        6'h25: sym = SYM_OR;
                        6'h26: sym = SYM_XOR;
                        6'h27: sym = SYM_NOR;
                        6'h2a: sym = SYM_SLT;
                        6'h2b: sym = SYM_SLTU;
                        default: ;
                    endcase
                end
                OP_REGIMM: begin
                    case (rt)
                        RT_BLTZ:   sym = SYM_BLTZ;
                        RT_BGEZ:   sym = SYM_BGEZ;
                        RT_BLTZAL: sym = SYM_BLTZAL;
                        RT_BGEZAL: sym = SYM_BGEZAL;
                        default: ;
                    endcase
                end
                OP_SPECIAL2: begin
                    case (funct)
                        F2_MADD:  sym = SYM_MADD;
                        F2_MADDU: sym = SYM_MADDU;
                        F2_MSUB:  sym = SYM_MSUB;
                        F2_MSUBU: sym = SYM_MSUBU;
                        F2_CLZ:   sym = SYM_CLZ;
                        F2_CLO:   sym = SYM_CLO;
                        default: ;
                    endcase
                end
                OP_COP0: begin
                    if (in_word[25] && funct == FN_ERET) begin
                        sym = SYM_ERET;
                    end else if (rs == CP0_MF) begin
                        sym = SYM_MFC0;
                    end else if (rs == CP0_MT) begin
                        sym = SYM_MTC0;
                    end
                end
                6'h02: sym = SYM_J;
                6'h03: sym = SYM_JAL;
                6'h04: sym = SYM_BEQ;
                6'h05: sym = SYM_BNE;
                6'h06: sym = SYM_BLEZ;
                6'h07: sym = SYM_BGTZ;
                6'h08: sym = SYM_ADDI;
                6'h09: sym = SYM_ADDIU;
                6'h0a: sym = SYM_SLTI;
                6'h0b: sym = SYM_SLTIU;
                6'h0c: sym = SYM_ANDI;
                6'h0d: sym = SYM_ORI;
                6'h0e: sym = SYM_XORI;
                6'h0f: sym = SYM_LUI;
                6'h20: sym = SYM_LB;
                6'h21: sym = SYM_LH;
                6'h23: sym = SYM_LW;
                6'h24: sym = SYM_LBU;
                6'h25: sym = SYM_LHU;
                6'h28: sym = SYM_SB;
                6'h29: sym = SYM_SH;
                6'h2b: sym = SYM_SW;
                default: ;
            endcase
        end
    end

    assign in_ready = !dec.valid || dec.ready; // empty or draining.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end else if (in_ready) begin
            dec.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec.sym <= sym;
            dec.rs  <= rs;
            dec.rt  <= rt;
            dec.rd  <= rd;
        end
    end

endmodule

//--- common/decode_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded instruction stream between the pipeline stages.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface decode_if;
    import mips_pkg::*;

    logic     valid;
    logic     ready;
    sym_t     sym;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;

    modport src (
        output valid, sym, rs, rt, rd,
        input  ready
    );

    modport dst (
        input  valid, sym, rs, rt, rd,
        output ready
    );

endinterface

//--- common/mips_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 decode types, symbol codes, format and function class codes,
// and the opcode and field codes of the instruction groups.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mips_pkg;

    typedef logic [31:0] instr_word_t;
    typedef logic [6:0]  sym_t;
    typedef logic [1:0]  format_t;
    typedef logic [3:0]  func_t;
    typedef logic [4:0]  reg_idx_t;

    localparam reg_idx_t REG_RA = 5'd31; // link register.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction format and function class
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam format_t FORMAT_R = 2'd0;
    localparam format_t FORMAT_I = 2'd1;
    localparam format_t FORMAT_J = 2'd2;

    localparam func_t FUNC_CALC_R    = 4'd0;
    localparam func_t FUNC_CALC_I    = 4'd1;
    localparam func_t FUNC_MEM_READ  = 4'd2;
    localparam func_t FUNC_MEM_WRITE = 4'd3;
    localparam func_t FUNC_BRANCH    = 4'd4;
    localparam func_t FUNC_JUMP      = 4'd5;
    localparam func_t FUNC_MULTDIV   = 4'd6;
    localparam func_t FUNC_CP0       = 4'd7;
    localparam func_t FUNC_OTHER     = 4'd8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction symbols
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam sym_t SYM_NOP    = 7'd0;
    localparam sym_t SYM_ADD    = 7'd1;
    localparam sym_t SYM_ADDU   = 7'd2;
    localparam sym_t SYM_SUB    = 7'd3;
    localparam sym_t SYM_SUBU   = 7'd4;
    localparam sym_t SYM_AND    = 7'd5;
    localparam sym_t SYM_OR     = 7'd6;
    localparam sym_t SYM_XOR    = 7'd7;
    localparam sym_t SYM_NOR    = 7'd8;
    localparam sym_t SYM_SLT    = 7'd9;
    localparam sym_t SYM_SLTU   = 7'd10;
    localparam sym_t SYM_SLL    = 7'd11;
    localparam sym_t SYM_SRL    = 7'd12;
    localparam sym_t SYM_SRA    = 7'd13;
    localparam sym_t SYM_SLLV   = 7'd14;
    localparam sym_t SYM_SRLV   = 7'd15;
    localparam sym_t SYM_SRAV   = 7'd16;
    localparam sym_t SYM_CLO    = 7'd17;
    localparam sym_t SYM_CLZ    = 7'd18;
    localparam sym_t SYM_ADDI   = 7'd19;
    localparam sym_t SYM_ADDIU  = 7'd20;
    localparam sym_t SYM_ANDI   = 7'd21;
    localparam sym_t SYM_ORI    = 7'd22;
    localparam sym_t SYM_XORI   = 7'd23;
    localparam sym_t SYM_LUI    = 7'd24;
    localparam sym_t SYM_SLTI   = 7'd25;
    localparam sym_t SYM_SLTIU  = 7'd26;
    localparam sym_t SYM_LW     = 7'd27;
    localparam sym_t SYM_LH     = 7'd28;
    localparam sym_t SYM_LHU    = 7'd29;
    localparam sym_t SYM_LB     = 7'd30;
    localparam sym_t SYM_LBU    = 7'd31;
    localparam sym_t SYM_SW     = 7'd32;
    localparam sym_t SYM_SH     = 7'd33;
    localparam sym_t SYM_SB     = 7'd34;
    localparam sym_t SYM_BEQ    = 7'd35;
    localparam sym_t SYM_BNE    = 7'd36;
    localparam sym_t SYM_BLEZ   = 7'd37;
    localparam sym_t SYM_BGTZ   = 7'd38;
    localparam sym_t SYM_BGEZ   = 7'd39;
    localparam sym_t SYM_BLTZ   = 7'd40;
    localparam sym_t SYM_BGEZAL = 7'd41;
    localparam sym_t SYM_BLTZAL = 7'd42;
    localparam sym_t SYM_J      = 7'd43;
    localparam sym_t SYM_JAL    = 7'd44;
    localparam sym_t SYM_JR     = 7'd45;
    localparam sym_t SYM_JALR   = 7'd46;
    localparam sym_t SYM_MULT   = 7'd47;
    localparam sym_t SYM_MULTU  = 7'd48;
    localparam sym_t SYM_DIV    = 7'd49;
    localparam sym_t SYM_DIVU   = 7'd50;
    localparam sym_t SYM_MFHI   = 7'd51;
    localparam sym_t SYM_MFLO   = 7'd52;
    localparam sym_t SYM_MTHI   = 7'd53;
    localparam sym_t SYM_MTLO   = 7'd54;
    localparam sym_t SYM_MADD   = 7'd55;
    localparam sym_t SYM_MADDU  = 7'd56;
    localparam sym_t SYM_MSUB   = 7'd57;
    localparam sym_t SYM_MSUBU  = 7'd58;
    localparam sym_t SYM_MFC0   = 7'd59;
    localparam sym_t SYM_MTC0   = 7'd60;
    localparam sym_t SYM_ERET   = 7'd61;
    localparam sym_t SYM_INVALID = 7'h7f; // unknown encoding.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // group opcodes and field codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_REGIMM   = 6'h01;
    localparam logic [5:0] OP_COP0     = 6'h10;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;

    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    localparam logic [5:0] F2_MADD  = 6'h00;
    localparam logic [5:0] F2_MADDU = 6'h01;
    localparam logic [5:0] F2_MSUB  = 6'h04;
    localparam logic [5:0] F2_MSUBU = 6'h05;
    localparam logic [5:0] F2_CLZ   = 6'h20;
    localparam logic [5:0] F2_CLO   = 6'h21;

    localparam logic [4:0] CP0_MF  = 5'h00; // rs field.
    localparam logic [4:0] CP0_MT  = 5'h04;
    localparam logic [5:0] FN_ERET = 6'h18; // with the CO bit set.

endpackage
